// ==== src/obj_pkg.sv ====
package obj_pkg;

    // CPU data, table bytes, X positions and line numbers
    typedef logic [7:0] byte_t;

    // Address inside one 64-byte attribute bank
    typedef logic [5:0] tbl_addr_t;

    // Pixel or colour index
    typedef logic [3:0] pxl_t;

    // Palette bank from the attribute byte, then the pixel
    typedef logic [7:0] pal_addr_t;

    // Code, row within the sprite, half select
    typedef logic [12:0] rom_addr_t;

    typedef logic [31:0] rom_word_t;

    // One accepted sprite, scanner to draw engine
    typedef struct packed {
        byte_t      xpos;
        byte_t      attr;
        byte_t      code;
        logic [3:0] row;
    } draw_req_t;

    typedef enum logic [1:0] {
        scan_idle,
        scan_first,
        scan_second,
        scan_wait
    } scan_state_t;

    typedef enum logic [1:0] {
        draw_idle,
        draw_fetch,
        draw_shift
    } draw_state_t;

    localparam int table_entries = 24;
    localparam int max_drawn     = 24;
    localparam int min_xpos      = 24;
    localparam int sprite_h      = 16;
    // Left edge of the sprite relative to xpos
    localparam int x_offset      = 6;
    localparam int flip_span     = 15;

endpackage

// ==== src/obj_attr_ram.sv ====
module obj_attr_ram import obj_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  tbl_addr_t cpu_addr,
    input  byte_t     cpu_din,
    output byte_t     cpu_q,
    input  tbl_addr_t scan_addr,
    output byte_t     scan_q
);

    byte_t mem [2**$bits(tbl_addr_t)];

    // CPU port, read returns the old byte on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[cpu_addr] <= cpu_din;
        end
        cpu_q <= mem[cpu_addr];
    end

    // Scanner port, read only
    always_ff @(posedge clk) begin
        scan_q <= mem[scan_addr];
    end

endmodule

// ==== src/obj_scan.sv ====
module obj_scan import obj_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      hinit,
    input  byte_t     vrender,
    output tbl_addr_t scan_addr,
    input  byte_t     hi_q,
    input  byte_t     lo_q,
    input  logic      draw_busy,
    output logic      draw_start,
    output draw_req_t draw_req
);

    scan_state_t st;
    logic [4:0]  entry;
    logic [4:0]  drawn;
    logic        pending;
    logic        last;
    byte_t       cur_xpos;
    byte_t       cur_attr;
    byte_t       spr_y;
    byte_t       row_raw;
    logic        inzone;
    logic        accept;

    // Odd byte is addressed only while the even byte arrives
    assign scan_addr = {entry, st == scan_first};

    // Y is stored inverted in the low bank
    assign spr_y   = ~lo_q;
    assign row_raw = vrender - spr_y - 8'd1;
    assign inzone  = vrender >= spr_y &&
                     {1'b0, vrender} < {1'b0, spr_y} + 9'(sprite_h);
    assign accept  = inzone && cur_xpos > byte_t'(min_xpos) &&
                     drawn < 5'(max_drawn);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= scan_idle;
            entry      <= '0;
            drawn      <= '0;
            pending    <= 1'b0;
            last       <= 1'b0;
            draw_start <= 1'b0;
        end else begin
            draw_start <= 1'b0;
            if (hinit) begin
                // New line, walk the table from entry 0
                st      <= scan_wait;
                entry   <= '0;
                drawn   <= '0;
                pending <= 1'b0;
                last    <= 1'b0;
            end else begin
                case (st)
                    scan_idle: begin
                        st <= scan_idle;
                    end
                    scan_first: begin
                        st <= scan_second;
                    end
                    scan_second: begin
                        if (accept) begin
                            pending <= 1'b1;
                            drawn   <= drawn + 5'd1;
                        end
                        last  <= entry == 5'(table_entries - 1);
                        entry <= entry + 5'd1;
                        st    <= scan_wait;
                    end
                    scan_wait: begin
                        // Hold the even address so the next read stays valid
                        if (pending) begin
                            if (!draw_busy) begin
                                draw_start <= 1'b1;
                                pending    <= 1'b0;
                            end
                        end else if (last) begin
                            st <= scan_idle;
                        end else begin
                            st <= scan_first;
                        end
                    end
                    default: begin
                        st <= scan_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st == scan_first) begin
            cur_xpos <= hi_q;
            cur_attr <= lo_q;
        end
        if (st == scan_second && accept) begin
            draw_req.xpos <= cur_xpos;
            draw_req.attr <= cur_attr;
            draw_req.code <= hi_q;
            // Bit 7 of attr is vflip
            draw_req.row  <= row_raw[3:0] ^ {4{cur_attr[7]}};
        end
    end

    // The draw engine only ever sees a start when it is free
    a_start_when_free: assert property (
        @(posedge clk) disable iff (rst) draw_start |-> !draw_busy
    ) else $error("draw_start while draw engine busy");

endmodule

// ==== src/obj_draw.sv ====
module obj_draw import obj_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      draw_start,
    input  draw_req_t draw_req,
    output logic      draw_busy,
    output rom_addr_t rom_addr,
    output logic      rom_cs,
    input  logic      rom_ok,
    input  rom_word_t rom_data,
    output pal_addr_t pal_addr,
    output byte_t     buf_addr,
    output logic      buf_we
);

    draw_state_t st;
    draw_req_t   req;
    rom_word_t   pxl_data;
    logic [2:0]  cnt;
    byte_t       wr_a;
    logic        shift_en;
    logic        hflip;
    byte_t       start_x;

    // Graphics word bit order: nibble k collects bits from four planes
    function automatic rom_word_t unpack_word(rom_word_t w);
        rom_word_t r;
        int        base;
        int        j;
        for (int k = 0; k < 8; k++) begin
            base = (k < 4) ? 0 : 16;
            j    = k % 4;
            r[4*k+3] = w[base + 8 + j];
            r[4*k+2] = w[base + 12 + j];
            r[4*k+1] = w[base + j];
            r[4*k]   = w[base + 4 + j];
        end
        return r;
    endfunction

    assign shift_en = st == draw_shift;
    assign hflip    = req.attr[6];
    assign pal_addr = {req.attr[3:0], pxl_data[3:0]};

    // Mirrored sprites start at the right edge and walk left
    assign start_x = draw_req.xpos + byte_t'(x_offset) +
                     (draw_req.attr[6] ? byte_t'(flip_span) : 8'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= draw_idle;
            draw_busy <= 1'b0;
            rom_cs    <= 1'b0;
            rom_addr  <= '0;
            cnt       <= '0;
            buf_we    <= 1'b0;
        end else begin
            // Write strobe trails by one cycle to meet the palette output
            buf_we <= shift_en;
            case (st)
                draw_idle: begin
                    if (draw_start) begin
                        rom_addr  <= {draw_req.code, draw_req.row, 1'b0};
                        rom_cs    <= 1'b1;
                        draw_busy <= 1'b1;
                        st        <= draw_fetch;
                    end
                end
                draw_fetch: begin
                    // Stall with a stable address until the ROM answers
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        cnt    <= 3'd7;
                        st     <= draw_shift;
                    end
                end
                draw_shift: begin
                    cnt <= cnt - 3'd1;
                    if (cnt == 3'd0) begin
                        if (rom_addr[0]) begin
                            draw_busy <= 1'b0;
                            st        <= draw_idle;
                        end else begin
                            // Second half of the row
                            rom_addr[0] <= 1'b1;
                            rom_cs      <= 1'b1;
                            st          <= draw_fetch;
                        end
                    end
                end
                default: begin
                    st <= draw_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        buf_addr <= wr_a;
        if (st == draw_idle && draw_start) begin
            req  <= draw_req;
            wr_a <= start_x;
        end
        if (st == draw_fetch && rom_ok) begin
            pxl_data <= unpack_word(rom_data);
        end
        if (shift_en) begin
            pxl_data <= pxl_data >> 4;
            wr_a     <= hflip ? wr_a - 8'd1 : wr_a + 8'd1;
        end
    end

    a_rom_hold: assert property (
        @(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr)
    ) else $error("ROM request dropped or changed before rom_ok");

endmodule

// ==== src/obj_palette.sv ====
module obj_palette import obj_pkg::*; (
    input  logic      clk,
    input  logic      prog_en,
    input  pal_addr_t prog_addr,
    input  pxl_t      prog_data,
    input  pal_addr_t rd_addr,
    output pxl_t      q
);

    pxl_t mem [2**$bits(pal_addr_t)];

    // Loaded once by the prog port before video starts
    always_ff @(posedge clk) begin
        if (prog_en) begin
            mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

// ==== src/obj_line_buffer.sv ====
module obj_line_buffer import obj_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  LHBL,
    input  logic  pxl_cen,
    input  byte_t wr_addr,
    input  pxl_t  wr_data,
    input  logic  we,
    input  byte_t rd_addr,
    output pxl_t  pxl
);

    pxl_t mem [2][2**$bits(byte_t)];
    logic parity;
    logic lhbl_l;
    logic wr_en;
    logic rd_en;
    logic wr_bank;
    logic rd_bank;

    // Front bank is shown while the back bank is drawn
    assign rd_bank = parity;
    assign wr_bank = ~parity;

    // Colour 0 is transparent
    assign wr_en = we && wr_data != '0;
    assign rd_en = pxl_cen && LHBL;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            parity <= 1'b0;
            lhbl_l <= 1'b0;
            pxl    <= '0;
        end else begin
            lhbl_l <= LHBL;
            // Swap at the start of horizontal blanking
            if (lhbl_l && !LHBL) begin
                parity <= ~parity;
            end
            if (rd_en) begin
                pxl <= mem[rd_bank][rd_addr];
            end else if (!LHBL) begin
                pxl <= '0;
            end
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        always_ff @(posedge clk) begin
            // Erase behind the read so the bank is clean for the next draw
            if (rd_en && rd_bank == b) begin
                mem[b][rd_addr] <= '0;
            end else if (wr_en && wr_bank == b) begin
                mem[b][wr_addr] <= wr_data;
            end
        end
    end

endmodule

// ==== src/obj_top.sv ====
module obj_top import obj_pkg::*; (
    input  logic      rst,
    input  logic      clk,
    input  logic      pxl_cen,
    // CPU bus
    input  tbl_addr_t cpu_addr,
    input  byte_t     cpu_dout,
    input  logic      cpu_rnw,
    input  logic      obj1_cs,
    input  logic      obj2_cs,
    output byte_t     obj_dout,
    // Video timing
    input  logic      hinit,
    input  logic      LHBL,
    input  byte_t     vrender,
    input  byte_t     hdump,
    // Palette PROM load
    input  logic      prog_en,
    input  pal_addr_t prog_addr,
    input  pxl_t      prog_data,
    // Graphics ROM
    output rom_addr_t rom_addr,
    output logic      rom_cs,
    input  logic      rom_ok,
    input  rom_word_t rom_data,
    output pxl_t      pxl
);

    logic      obj1_we;
    logic      obj2_we;
    logic      sel_hi;
    byte_t     hi_cpu_q;
    byte_t     lo_cpu_q;
    tbl_addr_t scan_addr;
    byte_t     hi_scan_q;
    byte_t     lo_scan_q;
    logic      draw_busy;
    logic      draw_start;
    draw_req_t draw_req;
    pal_addr_t pal_addr;
    pxl_t      pal_q;
    byte_t     buf_addr;
    logic      buf_we;

    assign obj1_we = obj1_cs & ~cpu_rnw;
    assign obj2_we = obj2_cs & ~cpu_rnw;

    // Bank select follows the access, obj1 first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_hi <= 1'b0;
        end else if (obj1_cs || obj2_cs) begin
            sel_hi <= obj1_cs;
        end
    end

    assign obj_dout = sel_hi ? hi_cpu_q : lo_cpu_q;

    // xpos and code
    obj_attr_ram u_high (
        .clk       (clk),
        .we        (obj1_we),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_dout),
        .cpu_q     (hi_cpu_q),
        .scan_addr (scan_addr),
        .scan_q    (hi_scan_q)
    );

    // attr and inverted Y
    obj_attr_ram u_low (
        .clk       (clk),
        .we        (obj2_we),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_dout),
        .cpu_q     (lo_cpu_q),
        .scan_addr (scan_addr),
        .scan_q    (lo_scan_q)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .hinit      (hinit),
        .vrender    (vrender),
        .scan_addr  (scan_addr),
        .hi_q       (hi_scan_q),
        .lo_q       (lo_scan_q),
        .draw_busy  (draw_busy),
        .draw_start (draw_start),
        .draw_req   (draw_req)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .draw_start (draw_start),
        .draw_req   (draw_req),
        .draw_busy  (draw_busy),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_ok     (rom_ok),
        .rom_data   (rom_data),
        .pal_addr   (pal_addr),
        .buf_addr   (buf_addr),
        .buf_we     (buf_we)
    );

    obj_palette u_palette (
        .clk       (clk),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rd_addr   (pal_addr),
        .q         (pal_q)
    );

    obj_line_buffer u_buffer (
        .clk     (clk),
        .rst     (rst),
        .LHBL    (LHBL),
        .pxl_cen (pxl_cen),
        .wr_addr (buf_addr),
        .wr_data (pal_q),
        .we      (buf_we),
        .rd_addr (hdump),
        .pxl     (pxl)
    );

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #10 clk = ~clk;
    end

endmodule

// ==== verification/obj_tb.sv ====
module obj_tb import obj_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    tbl_addr_t   cpu_addr;
    byte_t       cpu_dout;
    logic        cpu_rnw;
    logic        obj1_cs;
    logic        obj2_cs;
    byte_t       obj_dout;
    logic        hinit;
    logic        LHBL;
    byte_t       vrender;
    byte_t       hdump;
    logic        prog_en;
    pal_addr_t   prog_addr;
    pxl_t        prog_data;
    rom_addr_t   rom_addr;
    logic        rom_cs;
    logic        rom_ok;
    rom_word_t   rom_data;
    pxl_t        pxl;
    pxl_t        expected [256];
    logic [31:0] rng;
    logic [31:0] delay;

    tb_clock u_clock (.clk(clk));

    obj_top uut (
        .rst       (rst),
        .clk       (clk),
        .pxl_cen   (pxl_cen),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_rnw   (cpu_rnw),
        .obj1_cs   (obj1_cs),
        .obj2_cs   (obj2_cs),
        .obj_dout  (obj_dout),
        .hinit     (hinit),
        .LHBL      (LHBL),
        .vrender   (vrender),
        .hdump     (hdump),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data),
        .pxl       (pxl)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Four pixels of one colour spread over the four bit planes
    function automatic logic [15:0] plane_group(input pxl_t c);
        return {{4{c[2]}}, {4{c[3]}}, {4{c[0]}}, {4{c[1]}}};
    endfunction

    // Pixels 0-3 take the row and pixels 4-7 the code's low nibble plus the half
    function automatic rom_word_t rom_word(input rom_addr_t a);
        pxl_t lo;
        pxl_t hi;
        lo = a[4:1];
        hi = a[8:5] + pxl_t'(a[0]);
        return {plane_group(hi), plane_group(lo)};
    endfunction

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] exp_val,
                               input string what);
        if (actual !== exp_val) begin
            $display("Error at %0t: %s, got %0h, expected %0h", $time, what, actual, exp_val);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // Graphics ROM with a random answer delay
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_data <= '0;
            delay    <= '0;
            rng      <= 32'd95;
        end else begin
            rom_ok <= 1'b0;
            if (rom_cs && !rom_ok) begin
                if (delay == 32'd0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_word(rom_addr);
                    rng      <= xorshift(rng);
                    delay    <= rng % 32'd6;
                end else begin
                    delay <= delay - 32'd1;
                end
            end
        end
    end

    task automatic cpu_write(input logic [1:0] banks, input tbl_addr_t a, input byte_t d);
        @(posedge clk);
        cpu_addr <= a;
        cpu_dout <= d;
        cpu_rnw  <= 1'b0;
        obj1_cs  <= banks[0];
        obj2_cs  <= banks[1];
        @(posedge clk);
        obj1_cs  <= 1'b0;
        obj2_cs  <= 1'b0;
        cpu_rnw  <= 1'b1;
    endtask

    task automatic cpu_read(input logic [1:0] banks, input tbl_addr_t a, input byte_t exp_val);
        @(posedge clk);
        cpu_addr <= a;
        cpu_rnw  <= 1'b1;
        obj1_cs  <= banks[0];
        obj2_cs  <= banks[1];
        @(posedge clk);
        obj1_cs  <= 1'b0;
        obj2_cs  <= 1'b0;
        @(negedge clk);
        check_value(32'(obj_dout), 32'(exp_val), $sformatf("CPU readback at %0h", a));
    endtask

    task automatic palette_load(input pal_addr_t a, input pxl_t d);
        @(posedge clk);
        prog_en   <= 1'b1;
        prog_addr <= a;
        prog_data <= d;
        @(posedge clk);
        prog_en   <= 1'b0;
    endtask

    // The line is drawn once the scanner is back in idle and the draw engine is free
    task automatic wait_line_drawn();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (uut.u_scan.st != scan_idle || uut.draw_busy) begin
            if (cycles >= 2000) begin
                stop_failed("Timed out waiting for the sprite draw to finish the line");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // One video line of hinit, blanking and 256 visible pixels
    task automatic run_line(input byte_t v, input bit check);
        @(posedge clk);
        hinit   <= 1'b1;
        vrender <= v;
        @(posedge clk);
        hinit   <= 1'b0;
        wait_line_drawn();
        @(posedge clk);
        LHBL <= 1'b1;
        for (int h = 0; h < 256; h++) begin
            @(posedge clk);
            pxl_cen <= 1'b1;
            hdump   <= byte_t'(h);
            @(posedge clk);
            pxl_cen <= 1'b0;
            @(negedge clk);
            if (check) begin
                check_value(32'(pxl), 32'(expected[h]), $sformatf("pixel at hdump %0h", h));
            end
        end
        @(posedge clk);
        LHBL <= 1'b0;
        for (int h = 0; h < 256; h++) begin
            expected[h] = '0;
        end
    endtask

    task automatic replay_trace();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        byte_t       idx;
        fd = $fopen("verification/obj_trace.txt", "r");
        if (fd == 0) begin
            stop_failed("Cannot open the trace file verification/obj_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                f1 = '0;
                f2 = '0;
                f3 = '0;
                n = $sscanf(line, "%c %h %h %h", kind, f1, f2, f3);
                case (kind)
                    "W": cpu_write(f1[1:0], f2[5:0], f3[7:0]);
                    "R": cpu_read(f1[1:0], f2[5:0], f3[7:0]);
                    "C": palette_load(f1[7:0], f2[3:0]);
                    "P": begin
                        for (int i = 0; i < int'(f2); i++) begin
                            idx = f1[7:0] + byte_t'(i);
                            expected[idx] = f3[3:0];
                        end
                    end
                    "L": run_line(f1[7:0], 1'b1);
                    default: stop_failed($sformatf("Unknown trace record: %s", line));
                endcase
            end
        end
        $fclose(fd);
    endtask

    initial begin
        for (int c = 0; c < 100000; c++) begin
            @(posedge clk);
        end
        stop_failed("Simulation ran past its cycle limit");
    end

    initial begin
        rst       = 1'b1;
        pxl_cen   = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_rnw   = 1'b1;
        obj1_cs   = 1'b0;
        obj2_cs   = 1'b0;
        hinit     = 1'b0;
        LHBL      = 1'b0;
        vrender   = '0;
        hdump     = '0;
        prog_en   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        for (int h = 0; h < 256; h++) begin
            expected[h] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value(32'(rom_cs), 32'd0, "rom_cs after reset");
        check_value(32'(pxl), 32'd0, "pxl after reset");
        // An all-zero table holds no drawable sprite
        for (int a = 0; a < 64; a++) begin
            cpu_write(2'b11, tbl_addr_t'(a), 8'h00);
        end
        // Default palette maps each pixel to itself
        for (int a = 0; a < 256; a++) begin
            palette_load(pal_addr_t'(a), pxl_t'(a));
        end
        // Two lines flush both line buffer banks
        run_line(8'h00, 1'b0);
        run_line(8'h00, 1'b0);
        replay_trace();
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== verification/obj_trace.txt ====
# W banks addr data | R banks addr expected | C pal_addr colour | P hdump count colour | L vrender
# banks: 1 = obj1, 2 = obj2, 3 = both. ROM word: pixels 0-3 = row, pixels 4-7 = code[3:0] + half
# Palette defaults to the pixel value. P lines give the pixels shown by the next L line
W 1 00 40
W 1 01 25
W 2 00 01
W 2 01 D7
R 1 00 40
R 2 01 D7
R 3 01 25
C 15 9
L 2D
P 46 4 4
P 4A 4 9
P 4E 4 4
P 52 4 6
L 37
P 46 4 E
P 4A 4 9
P 4E 4 E
P 52 4 6
L 28
P 46 4 F
P 4A 4 9
P 4E 4 F
P 52 4 6
L 38
L 27
W 2 00 41
L 2D
P 46 4 6
P 4A 4 4
P 4E 4 9
P 52 4 4
W 2 00 81
L 2D
P 46 4 B
P 4A 4 9
P 4E 4 B
P 52 4 6
W 2 00 01
W 1 02 48
W 1 03 30
W 2 02 02
W 2 03 D7
C 24 C
W 1 04 18
W 2 04 01
W 2 05 D7
W 1 06 19
W 1 07 25
W 2 06 01
W 2 07 D7
R 3 06 19
L 2D
P 1F 4 4
P 23 4 9
P 27 4 4
P 2B 4 6
P 46 4 4
P 4A 4 9
P 4E 4 C
P 52 4 6
P 56 4 C
P 5A 4 1
L 27
L 27

// ==== compile.f ====
src/obj_pkg.sv
src/obj_attr_ram.sv
src/obj_scan.sv
src/obj_draw.sv
src/obj_palette.sv
src/obj_line_buffer.sv
src/obj_top.sv
verification/tb_clock.sv
verification/obj_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module obj_tb -f compile.f -o obj_sim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/obj_sim > sim.log 2>&1
grep -q "Verification failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Verification passed" sim.log && echo "Simulation PASSED" || { echo "No result"; exit 1; }
